/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  lookup_t   miss_req,
    input  logic      miss,
    input  logic      fill_done,
    input  line_t     fill_line,

    output logic      accept,
    output logic      replay,
    output logic      fill_start,
    output array_wr_t wr
);

    cache_state_e state;
    cache_state_e state_nxt;
    index_t       sweep_cnt;
    plru_t        plru_tab [num_sets];
    way_mask_t    victim;

    // tree lookup, bit 0 picks the pair
    function automatic way_mask_t pick_victim(plru_t p);
        if (!p[0]) begin
            return p[1] ? 4'b0010 : 4'b0001;
        end
        return p[2] ? 4'b1000 : 4'b0100;
    endfunction

    // point the tree away from the way just filled
    function automatic plru_t plru_next(plru_t p, way_mask_t w);
        plru_t n;
        n = p;
        case (w)
            4'b0001: n = {p[2], 1'b1, 1'b1};
            4'b0010: n = {p[2], 1'b0, 1'b1};
            4'b0100: n = {1'b1, p[1], 1'b0};
            4'b1000: n = {1'b0, p[1], 1'b0};
            default: n = p;
        endcase
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_reset:   if (sweep_cnt == index_t'(num_sets - 1)) state_nxt = st_idle;
            st_idle:    state_nxt = st_run;
            st_run:     if (miss) state_nxt = st_miss;
            st_miss:    state_nxt = st_refill;
            st_refill:  if (fill_done) state_nxt = st_finish;
            st_finish:  state_nxt = st_recover;
            st_recover: state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= st_reset;
            sweep_cnt <= '0;
            victim    <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_reset) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            if (state == st_run && miss) begin
                victim <= pick_victim(plru_tab[miss_req.index]);
            end
        end
    end

    // sweep clears the tree along with the tags
    always_ff @(posedge clk) begin
        if (state == st_reset) begin
            plru_tab[sweep_cnt] <= '0;
        end else if (state == st_finish) begin
            plru_tab[miss_req.index] <= plru_next(plru_tab[miss_req.index], victim);
        end
    end

    assign accept     = (state == st_run);
    assign replay     = (state == st_idle);
    assign fill_start = (state == st_miss);

    ////////////////////////////////////////////////////////////////////////////
    // array write port
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr      = '0;
        wr.line = fill_line;
        case (state)
            st_reset: begin
                // invalid tag into every way of one set
                wr.ways  = '1;
                wr.index = sweep_cnt;
            end
            st_finish: begin
                wr.ways       = victim;
                wr.index      = miss_req.index;
                wr.tag        = miss_req.tag;
                wr.valid      = 1'b1;
                wr.write_data = 1'b1;
            end
            default: wr.ways = '0;
        endcase
    end

endmodule

/* rtl/icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_ways    = 4;
    localparam int num_sets    = 128;
    localparam int burst_words = 8;

    typedef logic [31:0]           word_t;
    // address bits 31 to 12
    typedef logic [19:0]           tag_t;
    // address bits 11 to 5
    typedef logic [6:0]            index_t;
    typedef logic [127:0]          half_t;
    typedef logic [255:0]          line_t;
    typedef logic [num_ways-1:0]   way_mask_t;
    typedef logic [2:0]            plru_t;

    // one request in flight through the lookup stages
    typedef struct packed {
        logic   valid;
        tag_t   tag;
        index_t index;
        logic   half;
    } lookup_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // shared write port of the way arrays
    typedef struct packed {
        way_mask_t ways;
        index_t    index;
        tag_t      tag;
        logic      valid;
        line_t     line;
        logic      write_data;
    } array_wr_t;

    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_run,
        st_miss,
        st_refill,
        st_finish,
        st_recover
    } cache_state_e;

endpackage

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter logic [3:0] axi_id = 4'd3
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        inst_req,
    input  word_t       inst_addr,
    output logic        inst_addr_ok,
    output logic        inst_data_ok,
    output half_t       inst_rdata,

    output logic [3:0]  arid,
    output word_t       araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,

    input  logic [3:0]  rid,
    input  word_t       rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    logic      accept;
    logic      replay;
    logic      miss;
    logic      fill_start;
    logic      fill_done;
    line_t     fill_line;
    lookup_t   miss_req;
    index_t    rd_index;
    array_wr_t wr;
    tagv_t     tagv [num_ways];
    line_t     lines [num_ways];

    lookup_pipe u_lookup_pipe (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .accept       (accept),
        .replay       (replay),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .rd_index     (rd_index),
        .tagv         (tagv),
        .lines        (lines),
        .miss_req     (miss_req),
        .miss         (miss)
    );

    cache_ctrl u_cache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .miss_req   (miss_req),
        .miss       (miss),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .accept     (accept),
        .replay     (replay),
        .fill_start (fill_start),
        .wr         (wr)
    );

    refill_unit #(
        .axi_id (axi_id)
    ) u_refill_unit (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .miss_req   (miss_req),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .rid        (rid),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .fill_done  (fill_done),
        .fill_line  (fill_line)
    );

    // one storage block per way, all sharing the write port
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        way_array u_way (
            .clk      (clk),
            .rd_index (rd_index),
            .wr       (wr),
            .sel      (wr.ways[w]),
            .tagv     (tagv[w]),
            .line     (lines[w])
        );
    end

endmodule

/* rtl/lookup_pipe.sv */
`timescale 1ns/1ps

module lookup_pipe import icache_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    inst_req,
    input  word_t   inst_addr,
    input  logic    accept,
    input  logic    replay,
    output logic    inst_addr_ok,
    output logic    inst_data_ok,
    output half_t   inst_rdata,

    output index_t  rd_index,
    input  tagv_t   tagv [num_ways],
    input  line_t   lines [num_ways],

    output lookup_t miss_req,
    output logic    miss
);

    ////////////////////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////////////////////

    lookup_t   new_req;
    lookup_t   tag_stage;
    lookup_t   data_stage;
    tagv_t     data_tagv [num_ways];
    line_t     data_line [num_ways];
    logic      advance;
    way_mask_t hit_way;
    logic [1:0] hit_sel;

    assign new_req.valid = inst_req;
    assign new_req.tag   = inst_addr[31:12];
    assign new_req.index = inst_addr[11:5];
    assign new_req.half  = inst_addr[4];

    // last stage empty or leaving this cycle
    assign advance      = !data_stage.valid || inst_data_ok;
    assign inst_addr_ok = accept && advance;

    // new request goes straight to the arrays, replay re-reads the held one
    always_comb begin
        if (accept) begin
            rd_index = new_req.index;
        end else if (replay) begin
            rd_index = tag_stage.index;
        end else begin
            rd_index = data_stage.index;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tag_stage  <= '0;
            data_stage <= '0;
        end else begin
            if (inst_addr_ok) begin
                tag_stage <= new_req;
            end else if (advance) begin
                tag_stage.valid <= 1'b0;
            end
            if (advance) begin
                data_stage <= tag_stage;
            end
        end
    end

    // array readback follows the tag stage into the data stage
    always_ff @(posedge clk) begin
        if (advance || replay) begin
            for (int k = 0; k < num_ways; k++) begin
                data_tagv[k] <= tagv[k];
                data_line[k] <= lines[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < num_ways; k++) begin
            hit_way[k] = data_tagv[k].valid && (data_tagv[k].tag == data_stage.tag);
        end
    end

    // one-hot to way number
    always_comb begin
        hit_sel = 2'd0;
        for (int k = 0; k < num_ways; k++) begin
            if (hit_way[k]) begin
                hit_sel = 2'(k);
            end
        end
    end

    assign inst_rdata = data_stage.half ? data_line[hit_sel][255:128]
                                        : data_line[hit_sel][127:0];

    // compare result only counts while the controller is running
    assign inst_data_ok = accept && data_stage.valid && (|hit_way);
    assign miss         = data_stage.valid && !(|hit_way);
    assign miss_req     = data_stage;

endmodule

/* rtl/refill_unit.sv */
`timescale 1ns/1ps

module refill_unit import icache_pkg::*; #(
    parameter logic [3:0] axi_id = 4'd3
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       fill_start,
    input  lookup_t    miss_req,

    output logic [3:0] arid,
    output word_t      araddr,
    output logic [3:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic       arvalid,
    input  logic       arready,

    input  logic [3:0] rid,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,

    output logic       fill_done,
    output line_t      fill_line
);

    word_t      addr_q;
    logic       ar_pend;
    logic       busy;
    logic [2:0] word_cnt;
    word_t      line_buf [burst_words];
    logic       beat;

    // only beats tagged with our id land in the buffer
    assign beat = rready && rvalid && (rid == axi_id);

    // wrap burst, requested half first
    assign arid    = axi_id;
    assign araddr  = addr_q;
    assign arlen   = 4'(burst_words - 1);
    assign arsize  = 3'd2;
    assign arburst = 2'b10;
    assign arvalid = ar_pend;
    assign rready  = busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_pend   <= 1'b0;
            busy      <= 1'b0;
            fill_done <= 1'b0;
            word_cnt  <= '0;
        end else begin
            fill_done <= beat && rlast;
            if (fill_start) begin
                ar_pend  <= 1'b1;
                busy     <= 1'b1;
                word_cnt <= {miss_req.half, 2'b00};
            end else begin
                if (ar_pend && arready) begin
                    ar_pend <= 1'b0;
                end
                if (beat) begin
                    word_cnt <= word_cnt + 3'd1;
                    busy     <= !rlast;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            addr_q <= {miss_req.tag, miss_req.index, miss_req.half, 4'b0000};
        end
        if (beat) begin
            line_buf[word_cnt] <= rdata;
        end
    end

    // word 0 in the low bits
    for (genvar i = 0; i < burst_words; i++) begin : g_line
        assign fill_line[i*32 +: 32] = line_buf[i];
    end

endmodule

/* rtl/way_array.sv */
`timescale 1ns/1ps

module way_array import icache_pkg::*; (
    input  logic      clk,

    input  index_t    rd_index,
    input  array_wr_t wr,
    input  logic      sel,

    output tagv_t     tagv,
    output line_t     line
);

    tagv_t tagv_mem [num_sets];
    line_t line_mem [num_sets];
    tagv_t tagv_wdata;

    assign tagv_wdata.tag   = wr.tag;
    assign tagv_wdata.valid = wr.valid;

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (sel) begin
            tagv_mem[wr.index] <= tagv_wdata;
        end
        // sweep leaves the line data alone
        if (sel && wr.write_data) begin
            line_mem[wr.index] <= wr.line;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        tagv <= tagv_mem[rd_index];
        line <= line_mem[rd_index];
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module icache_tb -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/Vicache_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$log_file"; then
    exit 0
fi
exit 1

/* sources.f */
rtl/icache_pkg.sv
rtl/way_array.sv
rtl/lookup_pipe.sv
rtl/cache_ctrl.sv
rtl/refill_unit.sv
rtl/icache_top.sv
tb/axi_mem_model.sv
tb/icache_tb.sv

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model import icache_pkg::*; #(
    parameter word_t key  = 32'h5a5a_0000,
    parameter int    seed = 13
) (
    input  logic       clk,
    input  logic [3:0] arid,
    input  word_t      araddr,
    input  logic [3:0] arlen,
    input  logic [2:0] arsize,
    input  logic [1:0] arburst,
    input  logic       arvalid,
    output logic       arready,
    output logic [3:0] rid,
    output word_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    output int         ar_count,
    output word_t      last_araddr,
    output logic [3:0] last_arlen,
    output logic [1:0] last_arburst,
    output logic [3:0] last_arid,
    output logic [2:0] last_arsize
);

    logic       ar_fire;
    logic       r_fire;
    logic       ar_seen;
    int         delay;
    int         beat;

    // wrap bursts stay inside a (len + 1) * size window
    function automatic word_t beat_addr(word_t first, int n, logic [3:0] len,
                                        logic [2:0] size, logic [1:0] burst);
        word_t step;
        word_t total;
        word_t boundary;
        step  = word_t'(1) << size;
        total = step * (word_t'(len) + 1);
        if (burst != 2'b10) begin
            return first + word_t'(n) * step;
        end
        boundary = first & ~(total - 1);
        return boundary + ((first - boundary + word_t'(n) * step) % total);
    endfunction

    initial begin
        void'($urandom(seed));
        arready      = 1'b0;
        rvalid       = 1'b0;
        rlast        = 1'b0;
        rid          = '0;
        rdata        = '0;
        ar_count     = 0;
        last_araddr  = '0;
        last_arlen   = '0;
        last_arburst = '0;
        last_arid    = '0;
        last_arsize  = '0;
        delay        = -1;
        beat         = 0;
        forever begin
            // handshakes are decided by the values held through the cycle
            @(negedge clk);
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            ar_seen = (arvalid === 1'b1);
            if (ar_fire) begin
                last_araddr  = araddr;
                last_arlen   = arlen;
                last_arsize  = arsize;
                last_arburst = arburst;
                last_arid    = arid;
            end
            @(posedge clk);
            #1;
            if (ar_fire) begin
                arready  = 1'b0;
                delay    = -1;
                ar_count = ar_count + 1;
                beat     = 0;
                rvalid   = 1'b1;
                rid      = last_arid;
                rlast    = (last_arlen == 4'd0);
                rdata    = key ^ beat_addr(last_araddr, beat, last_arlen, last_arsize,
                                           last_arburst);
            end else if (r_fire) begin
                if (rlast) begin
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end else begin
                    beat  = beat + 1;
                    rlast = (beat == int'(last_arlen));
                    rdata = key ^ beat_addr(last_araddr, beat, last_arlen, last_arsize,
                                            last_arburst);
                end
            end
            // random wait of 0 to 3 cycles before arready
            if (ar_seen && !ar_fire && !arready) begin
                if (delay < 0) begin
                    delay = int'($urandom % 4);
                end
                if (delay == 0) begin
                    arready = 1'b1;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

/* tb/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

    localparam int         clk_period      = 100;
    localparam int         seed            = 13;
    localparam word_t      pattern_key     = 32'h5a5a_0000;
    localparam logic [3:0] axi_id          = 4'd3;
    localparam int         sweep_cycles    = 128;
    localparam int         num_tests       = 25;
    localparam int         watchdog_cycles = num_tests * 40 + 300;

    typedef struct packed {
        word_t addr;
        logic  new_burst;
    } test_entry_t;

    // set 2, then five tags in set 5, then mixed traffic over sets 9 and 120
    test_entry_t tests [num_tests] = '{
        '{32'h0000_1040, 1'b1}, '{32'h0000_1040, 1'b0}, '{32'h0000_1050, 1'b0},
        '{32'h0001_00a0, 1'b1}, '{32'h0001_10a0, 1'b1}, '{32'h0001_20a0, 1'b1},
        '{32'h0001_30b0, 1'b1}, '{32'h0001_00b0, 1'b0}, '{32'h0001_10a0, 1'b0},
        '{32'h0001_20b0, 1'b0}, '{32'h0001_30a0, 1'b0}, '{32'h0001_40a0, 1'b1},
        '{32'h0001_40a0, 1'b0}, '{32'h0002_0120, 1'b1}, '{32'h0002_0130, 1'b0},
        '{32'h0002_0120, 1'b0}, '{32'h0000_1050, 1'b0}, '{32'h0001_30b0, 1'b0},
        '{32'h0003_0f00, 1'b1}, '{32'h0003_0f10, 1'b0}, '{32'h0001_40b0, 1'b0},
        '{32'h0000_1040, 1'b0}, '{32'h0004_0f10, 1'b1}, '{32'h0003_0f00, 1'b0},
        '{32'h0004_0f00, 1'b0}
    };

    logic       clk;
    logic       rst;
    logic       inst_req;
    word_t      inst_addr;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    half_t      inst_rdata;
    logic [3:0] arid;
    word_t      araddr;
    logic [3:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    logic [3:0] rid;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    logic       rready;
    int         ar_count;
    word_t      last_araddr;
    logic [3:0] last_arlen;
    logic [1:0] last_arburst;
    logic [3:0] last_arid;
    logic [2:0] last_arsize;
    int         errors = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;

    icache_top #(.axi_id(axi_id)) UUT (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_addr_ok(inst_addr_ok), .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready), .rid(rid), .rdata(rdata), .rlast(rlast),
        .rvalid(rvalid), .rready(rready)
    );

    axi_mem_model #(.key(pattern_key), .seed(seed)) u_mem (
        .clk(clk), .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arvalid(arvalid), .arready(arready), .rid(rid), .rdata(rdata),
        .rlast(rlast), .rvalid(rvalid), .rready(rready), .ar_count(ar_count),
        .last_araddr(last_araddr), .last_arlen(last_arlen), .last_arburst(last_arburst),
        .last_arid(last_arid), .last_arsize(last_arsize)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // four words from the half-line base with the lowest address in the low bits
    function automatic half_t expected_half(word_t addr);
        half_t h;
        word_t base;
        base = {addr[31:4], 4'b0000};
        for (int k = 0; k < 4; k++) begin
            h[k*32 +: 32] = (base + word_t'(k * 4)) ^ pattern_key;
        end
        return h;
    endfunction

    task automatic check_value(string name, half_t got, half_t exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic log_result(string label, bit ok);
        if (ok) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("%s: %s", label, ok ? "ok" : "mismatch");
    endtask

    // no handshake may show up while the sets are being invalidated
    task automatic check_startup();
        int early_addr_ok;
        int early_data_ok;
        int early_arvalid;
        int errors_before;
        early_addr_ok = 0;
        early_data_ok = 0;
        early_arvalid = 0;
        errors_before = errors;
        repeat (sweep_cycles) begin
            @(negedge clk);
            early_addr_ok += (inst_addr_ok === 1'b1) ? 1 : 0;
            early_data_ok += (inst_data_ok === 1'b1) ? 1 : 0;
            early_arvalid += (arvalid === 1'b1) ? 1 : 0;
        end
        check_value("inst_addr_ok cycles in sweep", half_t'(early_addr_ok), '0);
        check_value("inst_data_ok cycles in sweep", half_t'(early_data_ok), '0);
        check_value("arvalid cycles in sweep", half_t'(early_arvalid), '0);
        log_result("[startup] sweep window", errors == errors_before);
    endtask

    // hold each request until a cycle with inst_addr_ok
    task automatic drive_requests();
        for (int i = 0; i < num_tests; i++) begin
            @(posedge clk);
            #1;
            inst_req  = 1'b1;
            inst_addr = tests[i].addr;
            do begin
                @(negedge clk);
            end while (!inst_addr_ok);
        end
        @(posedge clk);
        #1;
        inst_req  = 1'b0;
        inst_addr = '0;
    endtask

    // responses arrive in order and each burst lands before its own response
    task automatic check_responses();
        int    prev_count;
        int    errors_before;
        string label;
        prev_count = ar_count;
        for (int i = 0; i < num_tests; i++) begin
            do begin
                @(negedge clk);
            end while (inst_data_ok !== 1'b1);
            errors_before = errors;
            check_value("inst_rdata", inst_rdata, expected_half(tests[i].addr));
            check_value("address phases", half_t'(ar_count - prev_count),
                        half_t'(tests[i].new_burst));
            if (tests[i].new_burst) begin
                check_value("araddr", half_t'(last_araddr), {tests[i].addr[31:4], 4'b0000});
                check_value("arlen", half_t'(last_arlen), half_t'(7));
                check_value("arsize", half_t'(last_arsize), half_t'(2));
                check_value("arburst", half_t'(last_arburst), half_t'(2'b10));
                check_value("arid", half_t'(last_arid), half_t'(axi_id));
            end
            prev_count = ar_count;
            label = $sformatf("[%0d] addr %h burst %0d", i, tests[i].addr, tests[i].new_burst);
            log_result(label, errors == errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock, watchdog and main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run still busy after %0d clock periods", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        rst       = 1'b0;
        inst_req  = 1'b0;
        inst_addr = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        check_startup();
        fork
            drive_requests();
            check_responses();
        join
        $display("results: %0d of %0d tests ok, %0d failing checks", tests_ok,
                 tests_ok + tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
